/* common/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// --------------------------------------------------
// fetch front end constants
// --------------------------------------------------

// first virtual pc after reset, boot vector in kseg1
`define FETCH_RESET_PC 32'hbfc0_0000

// exception codes carried in the fetch bundle
`define EXC_NONE 5'd0
`define EXC_ADEL 5'd4

// number of expected records in the trace file
`define FETCH_TRACE_LEN 64

// words in the instruction memory image
`define FETCH_MEM_WORDS 1024

`endif

/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // --------------------------------------------------
    // instruction word views
    // --------------------------------------------------

    // immediate format, used for beq
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_form_t;

    // jump format, used for j and jal
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_form_t;

    // one 32-bit word, read as either format
    typedef union packed {
        i_form_t i_form;
        j_form_t j_form;
    } inst_word_t;

    // opcodes that change the fetch path
    localparam logic [5:0] OP_J   = 6'h02;
    localparam logic [5:0] OP_JAL = 6'h03;
    localparam logic [5:0] OP_BEQ = 6'h04;

    // --------------------------------------------------
    // stage to stage bundles
    // --------------------------------------------------

    // what fetch hands to the if/id buffer
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        inst_word_t  instr;
        logic        exception;
        logic [4:0]  exc_code;
    } fetch_bundle_t;

    // clear and jump from write-back
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* fetch/fetch_stage.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_stage (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire fetch_pkg::redirect_t redirect,
    input  wire [31:0]               next_pc,
    input  wire                      id_allowin,
    output logic                     inst_sram_en,
    output logic [31:0]              inst_sram_addr,
    input  wire [31:0]               inst_sram_rdata,
    output logic                     if_valid,
    output fetch_pkg::fetch_bundle_t if_bundle
);

    logic        fetch_on_r;
    logic        if_valid_r;
    logic        id_full_r;
    logic [31:0] pc_r;

    logic        mispredict;
    logic        misaligned;
    logic [31:0] pc_plus4;
    logic [31:0] req_addr;
    logic [31:0] req_paddr;

    // --------------------------------------------------
    // next request address
    // --------------------------------------------------
    assign pc_plus4 = pc_r + 32'd4;

    // decode holds a bundle whose successor is not the one in flight
    assign mispredict = id_full_r && if_valid_r && (pc_r != next_pc);

    // the wrong-path word is dropped, not handed on
    assign if_valid = if_valid_r && !mispredict;

    always_comb begin
        if (redirect.valid) begin
            req_addr = redirect.target;
        end else if (id_allowin && mispredict) begin
            req_addr = next_pc;
        end else if (id_allowin && if_valid) begin
            req_addr = pc_plus4;
        end else begin
            // re-read the outstanding word
            req_addr = pc_r;
        end
    end

    // kseg0/kseg1 fixed mapping, everything else unmapped
    always_comb begin
        if (req_addr[31:30] == 2'b10) begin
            req_paddr = {3'b000, req_addr[28:0]};
        end else begin
            req_paddr = req_addr;
        end
    end

    assign inst_sram_en   = fetch_on_r;
    assign inst_sram_addr = {req_paddr[31:2], 2'b00};

    // --------------------------------------------------
    // pc of the outstanding read
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_on_r <= 1'b0;
            if_valid_r <= 1'b0;
            id_full_r  <= 1'b0;
            pc_r       <= `FETCH_RESET_PC;
        end else begin
            fetch_on_r <= 1'b1;
            if_valid_r <= fetch_on_r;
            pc_r       <= req_addr;
            // tracks buffer occupancy so next_pc is only trusted when decode has a bundle
            if (redirect.valid) begin
                id_full_r <= 1'b0;
            end else if (id_allowin) begin
                id_full_r <= if_valid;
            end
        end
    end

    // --------------------------------------------------
    // bundle to the if/id buffer
    // --------------------------------------------------
    assign misaligned = (pc_r[1:0] != 2'b00);

    always_comb begin
        if_bundle.pc        = pc_r;
        if_bundle.npc       = pc_plus4;
        if_bundle.nnpc      = pc_r + 32'd8;
        if_bundle.instr     = inst_sram_rdata;
        if_bundle.exception = misaligned;
        if_bundle.exc_code  = misaligned ? `EXC_ADEL : `EXC_NONE;
    end

endmodule

`default_nettype wire

/* hdl/if_id_buffer.sv */
`default_nettype none

module if_id_buffer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       hold,
    input  wire                       redirect_valid,
    input  wire                       if_valid,
    input  wire fetch_pkg::fetch_bundle_t if_bundle,
    output logic                      id_allowin,
    output logic                      id_valid,
    output fetch_pkg::fetch_bundle_t  id_bundle
);

    import fetch_pkg::*;

    logic          valid_r;
    fetch_bundle_t bundle_r;
    logic          load;

    // --------------------------------------------------
    // occupancy
    // --------------------------------------------------
    assign id_allowin = !hold || !valid_r;
    assign load       = if_valid && id_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (redirect_valid) begin
            valid_r <= 1'b0;
        end else if (id_allowin) begin
            // drains when nothing arrives and execute is not holding
            valid_r <= if_valid;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (load) begin
            bundle_r <= if_bundle;
        end
    end

    assign id_valid  = valid_r;
    assign id_bundle = bundle_r;

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire                       id_valid,
    input  wire fetch_pkg::fetch_bundle_t id_bundle,
    output logic [31:0]               next_pc,
    output logic                      dec_valid
);

    import fetch_pkg::*;

    inst_word_t  instr;
    logic [31:0] npc;
    logic [31:0] jump_target;
    logic [31:0] branch_offset;
    logic [31:0] branch_target;
    logic        is_jump;
    logic        is_beq_always;

    assign instr = id_bundle.instr;
    assign npc   = id_bundle.npc;

    // --------------------------------------------------
    // instruction classes
    // --------------------------------------------------
    assign is_jump = (instr.j_form.opcode == OP_J) || (instr.j_form.opcode == OP_JAL);

    // beq $0, $0 always taken, no register read needed
    assign is_beq_always = (instr.i_form.opcode == OP_BEQ)
                        && (instr.i_form.rs == 5'd0)
                        && (instr.i_form.rt == 5'd0);

    // --------------------------------------------------
    // targets
    // --------------------------------------------------
    assign jump_target   = {npc[31:28], instr.j_form.target, 2'b00};
    assign branch_offset = {{14{instr.i_form.imm[15]}}, instr.i_form.imm, 2'b00};
    assign branch_target = npc + branch_offset;

    always_comb begin
        if (id_bundle.exception) begin
            // faulting word is garbage, write-back redirects
            next_pc = npc;
        end else if (is_jump) begin
            next_pc = jump_target;
        end else if (is_beq_always) begin
            next_pc = branch_target;
        end else begin
            next_pc = npc;
        end
    end

    assign dec_valid = id_valid;

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
`default_nettype none

module fetch_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       hold,
    input  wire fetch_pkg::redirect_t redirect,
    output wire                       inst_sram_en,
    output wire [31:0]                inst_sram_addr,
    input  wire [31:0]                inst_sram_rdata,
    output wire                       dec_valid,
    output wire fetch_pkg::fetch_bundle_t dec_bundle,
    output wire [31:0]                dec_next_pc
);

    import fetch_pkg::*;

    fetch_bundle_t if_bundle;
    logic          if_valid;
    logic          id_allowin;
    logic          id_valid;

    // --------------------------------------------------
    // fetch, buffer, decode
    // --------------------------------------------------
    fetch_stage fetch_stage_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect        (redirect),
        .next_pc         (dec_next_pc),
        .id_allowin      (id_allowin),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .if_valid        (if_valid),
        .if_bundle       (if_bundle)
    );

    if_id_buffer if_id_buffer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold           (hold),
        .redirect_valid (redirect.valid),
        .if_valid       (if_valid),
        .if_bundle      (if_bundle),
        .id_allowin     (id_allowin),
        .id_valid       (id_valid),
        .id_bundle      (dec_bundle)
    );

    decode_stage decode_stage_inst (
        .id_valid  (id_valid),
        .id_bundle (dec_bundle),
        .next_pc   (dec_next_pc),
        .dec_valid (dec_valid)
    );

endmodule

`default_nettype wire

/* verification/fetch_assertions.sv */
`default_nettype none

module fetch_assertions (
    input wire                           clk,
    input wire                           rst_n,
    input wire                           hold,
    input wire fetch_pkg::redirect_t     redirect,
    input wire                           inst_sram_en,
    input wire [31:0]                    inst_sram_addr,
    input wire                           dec_valid,
    input wire fetch_pkg::fetch_bundle_t dec_bundle,
    input wire [31:0]                    dec_next_pc
);

    import fetch_pkg::*;

    logic held;

    // buffer full and execute holding, no redirect
    assign held = dec_valid && hold && !redirect.valid;

    // --------------------------------------------------
    // fetch side
    // --------------------------------------------------
    addr_stable_under_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (held && $past(held)) |-> (inst_sram_en && $stable(inst_sram_addr))
    ) else $error("instruction address moved while the buffer was held");

    // --------------------------------------------------
    // decode side
    // --------------------------------------------------
    redirect_empties_buffer: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect.valid |=> !dec_valid
    ) else $error("decode still valid in the cycle after a redirect");

    control_outputs_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({inst_sram_en, inst_sram_addr, dec_valid})
    ) else $error("unknown value on a control output");

    // payload only meaningful while decode is valid
    bundle_known_when_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> !$isunknown({dec_bundle, dec_next_pc})
    ) else $error("unknown value on the decode bundle");

endmodule

bind fetch_top fetch_assertions fetch_assertions_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .hold           (hold),
    .redirect       (redirect),
    .inst_sram_en   (inst_sram_en),
    .inst_sram_addr (inst_sram_addr),
    .dec_valid      (dec_valid),
    .dec_bundle     (dec_bundle),
    .dec_next_pc    (dec_next_pc)
);

`default_nettype wire

/* verification/fetch_tb.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_tb;

    import fetch_pkg::*;

    logic          clk;
    logic          rst_n;
    logic          hold;
    redirect_t     redirect;
    logic          inst_sram_en;
    logic [31:0]   inst_sram_addr;
    logic [31:0]   inst_sram_rdata;
    logic          dec_valid;
    fetch_bundle_t dec_bundle;
    logic [31:0]   dec_next_pc;

    // sram image, the window starts at the boot vector's physical address
    logic [31:0] mem [0:`FETCH_MEM_WORDS-1];
    logic        sram_range_error;

    // expected records from the trace
    logic [31:0] rec_pc     [0:`FETCH_TRACE_LEN-1];
    logic [31:0] rec_instr  [0:`FETCH_TRACE_LEN-1];
    logic        rec_exc    [0:`FETCH_TRACE_LEN-1];
    logic [4:0]  rec_code   [0:`FETCH_TRACE_LEN-1];
    int          rec_hold   [0:`FETCH_TRACE_LEN-1];
    logic        rec_rv     [0:`FETCH_TRACE_LEN-1];
    logic [31:0] rec_target [0:`FETCH_TRACE_LEN-1];
    int          rec_count;
    int          error_count;

    fetch_top fetch_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .hold            (hold),
        .redirect        (redirect),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .dec_valid       (dec_valid),
        .dec_bundle      (dec_bundle),
        .dec_next_pc     (dec_next_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // sram model, one cycle read latency
    // --------------------------------------------------
    initial begin
        inst_sram_rdata  = 32'h0;
        sram_range_error = 1'b0;
    end

    always @(posedge clk) begin
        if (inst_sram_en) begin
            if (inst_sram_addr[31:12] != 20'h1fc00) begin
                sram_range_error <= 1'b1;
            end
            inst_sram_rdata <= mem[inst_sram_addr[11:2]];
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // kseg0 and kseg1 drop the top three bits
    function automatic logic [31:0] map_addr(input logic [31:0] vaddr);
        if (vaddr[31:29] == 3'b100 || vaddr[31:29] == 3'b101) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

    // successor of a fetched word by the jump and branch-always rules
    function automatic logic [31:0] expected_next_pc(input logic [31:0] pc,
                                                     input inst_word_t  w,
                                                     input logic        exc);
        logic [31:0] npc;
        logic [31:0] offset;
        npc    = pc + 32'd4;
        offset = {{16{w.i_form.imm[15]}}, w.i_form.imm};
        if (exc) begin
            return npc;
        end
        if (w.j_form.opcode == OP_J || w.j_form.opcode == OP_JAL) begin
            return (npc & 32'hf000_0000) | ({6'd0, w.j_form.target} << 2);
        end
        if (w.i_form.opcode == OP_BEQ && w.i_form.rs == 5'd0 && w.i_form.rt == 5'd0) begin
            return npc + (offset << 2);
        end
        return npc;
    endfunction

    task automatic fail_run(input string what);
        error_count++;
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] exc;
        logic [31:0] code;
        int          hv;
        logic [31:0] rv;
        logic [31:0] tgt;
        // unwritten words differ by address
        for (int i = 0; i < `FETCH_MEM_WORDS; i++) begin
            mem[i] = (32'h1fc0_0000 + (i << 2)) ^ 32'hac5a_0000;
        end
        rec_count = 0;
        fd = $fopen("verification/fetch_trace.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the trace file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] == "M") begin
                n = $sscanf(line, "M %h %h", a, d);
                if (n != 2 || a[31:12] != 20'h1fc00) begin
                    fail_run("bad memory line in the trace file");
                end
                mem[a[11:2]] = d;
            end else if (n > 0 && line.len() > 0 && line[0] == "R") begin
                n = $sscanf(line, "R %h %h %h %h %d %h %h", pc, ins, exc, code, hv, rv, tgt);
                if (n != 7 || rec_count >= `FETCH_TRACE_LEN) begin
                    fail_run("bad record line in the trace file");
                end
                rec_pc[rec_count]     = pc;
                rec_instr[rec_count]  = ins;
                rec_exc[rec_count]    = exc[0];
                rec_code[rec_count]   = code[4:0];
                rec_hold[rec_count]   = hv;
                rec_rv[rec_count]     = rv[0];
                rec_target[rec_count] = tgt;
                rec_count++;
            end
        end
        $fclose(fd);
        if (rec_count == 0) begin
            fail_run("the trace file holds no records");
        end
    endtask

    // one decoded bundle leaving decode, checked against trace and rules
    task automatic check_record(input int idx, input logic [31:0] exp_pc,
                                output logic [31:0] exp_next);
        logic        exp_exc;
        logic [31:0] exp_code;
        logic [31:0] paddr;
        logic [31:0] exp_instr;
        exp_exc   = (exp_pc[1:0] != 2'b00);
        exp_code  = exp_exc ? {27'd0, `EXC_ADEL} : 32'd0;
        paddr     = map_addr(exp_pc);
        exp_instr = mem[paddr[11:2]];
        exp_next  = expected_next_pc(exp_pc, exp_instr, exp_exc);
        check_value("dec_bundle.pc", dec_bundle.pc, exp_pc);
        check_value("trace pc", rec_pc[idx], exp_pc);
        check_value("dec_bundle.npc", dec_bundle.npc, exp_pc + 32'd4);
        check_value("dec_bundle.nnpc", dec_bundle.nnpc, exp_pc + 32'd8);
        check_value("dec_bundle.instr", dec_bundle.instr, exp_instr);
        check_value("trace instr", dec_bundle.instr, rec_instr[idx]);
        check_value("dec_bundle.exception", {31'd0, dec_bundle.exception}, {31'd0, exp_exc});
        check_value("trace exception", {31'd0, rec_exc[idx]}, {31'd0, exp_exc});
        check_value("dec_bundle.exc_code", {27'd0, dec_bundle.exc_code}, exp_code);
        check_value("trace exc_code", {27'd0, rec_code[idx]}, exp_code);
        check_value("dec_next_pc", dec_next_pc, exp_next);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] seed;
        logic [31:0] exp_pc;
        logic [31:0] exp_next;
        logic        next_hold;
        redirect_t   next_redirect;
        logic        seen_en;
        int          idx;
        int          idle;
        int          burst;
        int          hold_left;

        rst_n       = 1'b0;
        hold        = 1'b0;
        redirect    = '0;
        error_count = 0;
        load_trace();

        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
        end
        #2;
        check_value("dec_valid", {31'd0, dec_valid}, 32'd0);
        check_value("inst_sram_en", {31'd0, inst_sram_en}, 32'd0);
        rst_n = 1'b1;

        seed      = 32'hf352_4c08;
        exp_pc    = `FETCH_RESET_PC;
        exp_next  = 32'd0;
        seen_en   = 1'b0;
        idx       = 0;
        idle      = 0;
        burst     = 0;
        hold_left = rec_hold[0];

        while (idx < rec_count) begin
            @(posedge clk);
            #2;
            if (sram_range_error) begin
                fail_run("instruction SRAM read outside the modelled window");
            end
            if (!seen_en && inst_sram_en) begin
                seen_en = 1'b1;
                check_value("inst_sram_addr", inst_sram_addr, 32'h1fc0_0000);
            end

            next_hold     = 1'b0;
            next_redirect = '0;
            if (dec_valid && hold_left > 0) begin
                next_hold = 1'b1;
                hold_left--;
            end else if (burst > 0) begin
                next_hold = 1'b1;
                burst--;
            end else begin
                seed = xorshift(seed);
                if (seed[2:0] == 3'd0) begin
                    burst = {30'd0, seed[5:4]};
                end
            end

            if (dec_valid && !next_hold) begin
                check_record(idx, exp_pc, exp_next);
                if (rec_rv[idx]) begin
                    next_redirect.valid  = 1'b1;
                    next_redirect.target = rec_target[idx];
                    exp_pc = rec_target[idx];
                end else begin
                    exp_pc = exp_next;
                end
                idx++;
                if (idx < rec_count) begin
                    hold_left = rec_hold[idx];
                end
                idle = 0;
            end else begin
                idle++;
                if (idle > 40) begin
                    fail_run("timeout waiting for the next decoded instruction");
                end
            end

            hold     = next_hold;
            redirect = next_redirect;
        end

        @(posedge clk);
        #2;
        hold     = 1'b0;
        redirect = '0;

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/fetch_pkg.sv
fetch/fetch_stage.sv
hdl/if_id_buffer.sv
hdl/decode_stage.sv
hdl/fetch_top.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv

/* Makefile */
# Verilator build for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(SIM_BIN) 2>&1); \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		echo "simulation did not report a pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

/* verification/fetch_trace.txt */
# M <physical address> <instruction word>
# R <pc> <instr> <exception> <exc_code> <hold cycles> <redirect valid> <redirect target>
M 1fc00000 00000000
M 1fc00004 24010001
M 1fc00008 24020002
M 1fc0000c 0bf00040
M 1fc00010 24030003
M 1fc00100 24040004
M 1fc00104 1000003e
M 1fc00200 24050005
M 1fc00204 10220010
M 1fc00208 24070007
M 1fc00300 24080008
M 1fc00400 24090009
M 1fc00404 0ff00140
M 1fc00500 240a000a
M 1fc00504 240b000b
M 1fc00508 1000fffd
R bfc00000 00000000 0 00 0 0 00000000
R bfc00004 24010001 0 00 2 0 00000000
R bfc00008 24020002 0 00 0 0 00000000
R bfc0000c 0bf00040 0 00 1 0 00000000
R bfc00100 24040004 0 00 0 0 00000000
R bfc00104 1000003e 0 00 3 0 00000000
R bfc00200 24050005 0 00 0 0 00000000
R bfc00204 10220010 0 00 0 0 00000000
R bfc00208 24070007 0 00 0 1 9fc00302
R 9fc00302 24080008 1 04 2 1 9fc00400
R 9fc00400 24090009 0 00 0 0 00000000
R 9fc00404 0ff00140 0 00 1 0 00000000
R 9fc00500 240a000a 0 00 0 0 00000000
R 9fc00504 240b000b 0 00 0 0 00000000
R 9fc00508 1000fffd 0 00 2 0 00000000
R 9fc00500 240a000a 0 00 0 0 00000000
R 9fc00504 240b000b 0 00 0 0 00000000
